//--- common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// byte address: tag 31..10, set 9..6, beat 5..3, byte 2..0
	typedef logic [31:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [7:0] strb_t;
	typedef logic [21:0] tag_t;
	typedef logic [3:0] set_idx_t;
	typedef logic [3:0] way_oh_t;

	// one data-RAM row holds a pair of beats
	typedef logic [127:0] line_half_t;
	// set index on top, beat pair below
	typedef logic [5:0] ram_addr_t;

	typedef logic [3:0] apb_addr_t;
	typedef logic [31:0] reg_word_t;

	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 16;
	localparam int BEATS_PER_LINE = 8;

	// register map
	localparam apb_addr_t REG_CTRL = 4'h0;
	localparam apb_addr_t REG_HITS = 4'h4;
	localparam apb_addr_t REG_MISSES = 4'h8;

endpackage

`default_nettype wire

//--- common/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
	import dcache_pkg::*;

	// read address and read data
	logic ar_valid;
	addr_t ar_addr;
	logic ar_ready;
	logic r_valid;
	data_t r_data;
	logic r_last;

	// single-beat store, address and data travel together
	logic aw_valid;
	addr_t aw_addr;
	logic aw_ready;
	logic w_valid;
	data_t w_data;
	strb_t w_strb;
	logic w_ready;
	logic b_valid;

	modport cache (
		output ar_valid, ar_addr, aw_valid, aw_addr, w_valid, w_data, w_strb,
		input ar_ready, r_valid, r_data, r_last, aw_ready, w_ready, b_valid
	);

	modport mem (
		input ar_valid, ar_addr, aw_valid, aw_addr, w_valid, w_data, w_strb,
		output ar_ready, r_valid, r_data, r_last, aw_ready, w_ready, b_valid
	);

endinterface

`default_nettype wire

//--- common/dcache_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_cfg_if;

	logic enable;
	// one-cycle pulse
	logic invalidate;
	// event strobes, one per read
	logic read_hit;
	logic read_miss;

	modport regs (output enable, invalidate, input read_hit, read_miss);

	modport ctrl (input enable, invalidate, output read_hit, read_miss);

endinterface

`default_nettype wire

//--- dcache/dcache_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_ram (
	input wire clk,
	input wire en,
	input wire we,
	input wire dcache_pkg::ram_addr_t addr,
	input wire dcache_pkg::line_half_t bwen,
	input wire dcache_pkg::line_half_t wdata,
	output dcache_pkg::line_half_t rdata
);
	import dcache_pkg::*;

	localparam int ROWS = 2 ** $bits(ram_addr_t);

	line_half_t rows [ROWS];

	always_ff @(posedge clk) begin
		if (en) begin
			// only bits set in bwen are replaced
			if (we) begin
				rows[addr] <= (rows[addr] & ~bwen) | (wdata & bwen);
			end
			rdata <= rows[addr];
		end
	end

endmodule

`default_nettype wire

//--- dcache/dcache_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_regs (
	input wire clk,
	input wire rst,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire dcache_pkg::apb_addr_t paddr,
	input wire dcache_pkg::reg_word_t pwdata,
	output dcache_pkg::reg_word_t prdata,
	dcache_cfg_if.regs cfg
);
	import dcache_pkg::*;

	reg_word_t hit_cnt;
	reg_word_t miss_cnt;
	logic wr_access;
	logic cnt_clear;

	// counters stick at all ones
	function automatic reg_word_t sat_inc(input reg_word_t value, input logic event_seen);
		if (event_seen && (value != '1)) begin
			return value + 32'd1;
		end
		return value;
	endfunction

	// zero wait states, writes land in the access phase
	assign wr_access = psel && penable && pwrite;
	// a write to either counter clears both
	assign cnt_clear = wr_access && ((paddr == REG_HITS) || (paddr == REG_MISSES));

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg.enable <= 1'b1;
			cfg.invalidate <= 1'b0;
		end else begin
			cfg.invalidate <= wr_access && (paddr == REG_CTRL) && pwdata[1];
			if (wr_access && (paddr == REG_CTRL)) begin
				cfg.enable <= pwdata[0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst || cnt_clear) begin
			hit_cnt <= '0;
			miss_cnt <= '0;
		end else begin
			hit_cnt <= sat_inc(hit_cnt, cfg.read_hit);
			miss_cnt <= sat_inc(miss_cnt, cfg.read_miss);
		end
	end

	always_comb begin
		case (paddr)
			// invalidate bit always reads back as zero
			REG_CTRL: prdata = {30'b0, 1'b0, cfg.enable};
			REG_HITS: prdata = hit_cnt;
			REG_MISSES: prdata = miss_cnt;
			default: prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- dcache/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
	input wire clk,
	input wire rst,
	input wire req_valid,
	input wire req_write,
	input wire dcache_pkg::addr_t req_addr,
	input wire dcache_pkg::data_t req_wdata,
	input wire dcache_pkg::strb_t req_strb,
	output logic resp_ready,
	output dcache_pkg::data_t resp_rdata,
	mem_bus_if.cache mem,
	dcache_cfg_if.ctrl cfg,
	output dcache_pkg::way_oh_t ram_en,
	output logic ram_we,
	output dcache_pkg::ram_addr_t ram_addr,
	output dcache_pkg::line_half_t ram_bwen,
	output dcache_pkg::line_half_t ram_wdata,
	input wire dcache_pkg::line_half_t ram_rdata0,
	input wire dcache_pkg::line_half_t ram_rdata1,
	input wire dcache_pkg::line_half_t ram_rdata2,
	input wire dcache_pkg::line_half_t ram_rdata3
);
	import dcache_pkg::*;

	typedef enum logic [1:0] {IDLE, READ_BURST, RESPOND, STORE_WAIT} state_t;

	state_t state;
	tag_t tags [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] valid [NUM_WAYS];
	tag_t req_tag;
	set_idx_t req_set;
	way_oh_t hit_raw;
	way_oh_t hit_way;
	way_oh_t repl_ptr;
	way_oh_t fill_way;
	way_oh_t resp_sel;
	logic fill_en;
	logic fill_last;
	logic inv_pending;
	logic accept;
	logic [2:0] beat_cnt;
	data_t byte_mask;
	line_half_t sel_row;

	assign req_tag = req_addr[31:10];
	assign req_set = req_addr[9:6];

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_raw[w] = valid[w][req_set] && (tags[w][req_set] == req_tag);
		end
		for (int b = 0; b < 8; b++) begin
			byte_mask[b*8 +: 8] = {8{req_strb[b]}};
		end
	end

	// reads only hit while the cache is enabled
	assign hit_way = cfg.enable ? hit_raw : '0;
	// no new request in the cycle of its own response or before an invalidate
	assign accept = (state == IDLE) && req_valid && !resp_ready && !inv_pending;
	assign fill_last = (state == READ_BURST) && mem.r_valid && mem.r_last && fill_en;

	assign mem.ar_addr = {req_addr[31:6], 6'b0};
	assign mem.aw_addr = req_addr;
	assign mem.w_data = req_wdata;
	assign mem.w_strb = req_strb;

	always_comb begin
		ram_en = '0;
		ram_we = 1'b0;
		ram_addr = {req_set, req_addr[5:4]};
		ram_bwen = req_addr[3] ? {byte_mask, 64'b0} : {64'b0, byte_mask};
		ram_wdata = {req_wdata, req_wdata};
		if (accept && !req_write) begin
			ram_en = hit_way;
		end else if (accept && req_write) begin
			// a store hit keeps the cached copy in step, even when disabled
			ram_en = hit_raw;
			ram_we = 1'b1;
		end else if ((state == READ_BURST) && mem.r_valid && fill_en) begin
			// even beats go to the low half of the row
			ram_en = fill_way;
			ram_we = 1'b1;
			ram_addr = {req_set, beat_cnt[2:1]};
			ram_bwen = beat_cnt[0] ? {{64{1'b1}}, 64'b0} : {64'b0, {64{1'b1}}};
			ram_wdata = {mem.r_data, mem.r_data};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid[w] <= '0;
			end
		end else if ((state == IDLE) && inv_pending) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid[w] <= '0;
			end
		end else if (fill_last) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					valid[w][req_set] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_last) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					tags[w][req_set] <= req_tag;
				end
			end
		end
	end

	// a pulse during a miss or store waits here until IDLE
	always_ff @(posedge clk) begin
		if (rst) begin
			inv_pending <= 1'b0;
		end else if (cfg.invalidate) begin
			inv_pending <= 1'b1;
		end else if (state == IDLE) begin
			inv_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			repl_ptr <= 4'b0001;
		end else if (state == IDLE) begin
			repl_ptr <= {repl_ptr[2:0], repl_ptr[3]};
		end
	end

	assign sel_row = ({128{resp_sel[0]}} & ram_rdata0) | ({128{resp_sel[1]}} & ram_rdata1) |
		({128{resp_sel[2]}} & ram_rdata2) | ({128{resp_sel[3]}} & ram_rdata3);

	// wanted beat is grabbed from the burst, hits take it from the RAM row
	always_ff @(posedge clk) begin
		if ((state == READ_BURST) && mem.r_valid && (beat_cnt == req_addr[5:3])) begin
			resp_rdata <= mem.r_data;
		end else if ((state == RESPOND) && (resp_sel != '0)) begin
			resp_rdata <= req_addr[3] ? sel_row[127:64] : sel_row[63:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			resp_ready <= 1'b0;
			mem.ar_valid <= 1'b0;
			mem.aw_valid <= 1'b0;
			mem.w_valid <= 1'b0;
			cfg.read_hit <= 1'b0;
			cfg.read_miss <= 1'b0;
			beat_cnt <= '0;
			fill_way <= '0;
			fill_en <= 1'b0;
			resp_sel <= '0;
		end else begin
			resp_ready <= 1'b0;
			cfg.read_hit <= accept && !req_write && (hit_way != '0);
			cfg.read_miss <= accept && !req_write && (hit_way == '0);
			case (state)
				IDLE: begin
					if (accept && req_write) begin
						mem.aw_valid <= 1'b1;
						mem.w_valid <= 1'b1;
						state <= STORE_WAIT;
					end else if (accept && (hit_way != '0)) begin
						resp_sel <= hit_way;
						state <= RESPOND;
					end else if (accept) begin
						// enable is sampled once so a miss fills all or nothing
						mem.ar_valid <= 1'b1;
						beat_cnt <= '0;
						fill_way <= repl_ptr;
						fill_en <= cfg.enable;
						resp_sel <= '0;
						state <= READ_BURST;
					end
				end
				READ_BURST: begin
					if (mem.ar_valid && mem.ar_ready) begin
						mem.ar_valid <= 1'b0;
					end
					if (mem.r_valid) begin
						beat_cnt <= beat_cnt + 3'd1;
						if (mem.r_last) begin
							state <= RESPOND;
						end
					end
				end
				RESPOND: begin
					resp_ready <= 1'b1;
					state <= IDLE;
				end
				STORE_WAIT: begin
					if (mem.aw_valid && mem.aw_ready && mem.w_ready) begin
						mem.aw_valid <= 1'b0;
						mem.w_valid <= 1'b0;
					end
					if (mem.b_valid) begin
						resp_ready <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/backing_mem.sv
`timescale 1ns/1ps
`default_nettype none

module backing_mem #(
	parameter int MEM_WORDS = 512
) (
	input wire clk,
	input wire rst,
	mem_bus_if.mem bus
);
	import dcache_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	typedef logic [IDX_W-1:0] word_idx_t;

	data_t mem_words [MEM_WORDS];
	logic rd_active;
	logic [25:0] rd_line;
	logic [2:0] rd_beat;
	logic idle;
	logic wr_fire;
	word_idx_t rd_idx;
	word_idx_t wr_idx;

	// addresses alias modulo the array size
	function automatic word_idx_t word_index(input logic [28:0] word_addr);
		return word_idx_t'(word_addr % MEM_WORDS);
	endfunction

	// 0xC0DE0000 plus the index in the high half and its complement below
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem_words[i] = {32'hC0DE_0000 + 32'(i), ~32'(i)};
		end
	end

	assign idle = !rd_active && !bus.b_valid;
	assign bus.ar_ready = idle;
	assign bus.aw_ready = idle;
	assign bus.w_ready = idle;

	assign rd_idx = word_index({rd_line, rd_beat});
	assign wr_idx = word_index(bus.aw_addr[31:3]);
	assign wr_fire = bus.aw_valid && bus.aw_ready && bus.w_valid && bus.w_ready;

	assign bus.r_valid = rd_active;
	assign bus.r_data = mem_words[rd_idx];
	assign bus.r_last = rd_active && (rd_beat == 3'(BEATS_PER_LINE - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_active <= 1'b0;
			rd_beat <= '0;
			bus.b_valid <= 1'b0;
		end else begin
			// response one cycle after the write is taken
			bus.b_valid <= wr_fire;
			if (bus.ar_valid && bus.ar_ready) begin
				rd_active <= 1'b1;
				rd_beat <= '0;
			end else if (rd_active) begin
				rd_beat <= rd_beat + 3'd1;
				if (bus.r_last) begin
					rd_active <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus.ar_valid && bus.ar_ready) begin
			rd_line <= bus.ar_addr[31:6];
		end
	end

	always @(posedge clk) begin
		if (wr_fire) begin
			for (int b = 0; b < 8; b++) begin
				if (bus.w_strb[b]) begin
					mem_words[wr_idx][b*8 +: 8] <= bus.w_data[b*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
	parameter int MEM_WORDS = 512
) (
	input wire clk,
	input wire rst,
	input wire req_valid,
	input wire req_write,
	input wire dcache_pkg::addr_t req_addr,
	input wire dcache_pkg::data_t req_wdata,
	input wire dcache_pkg::strb_t req_strb,
	output wire resp_ready,
	output wire dcache_pkg::data_t resp_rdata,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire dcache_pkg::apb_addr_t paddr,
	input wire dcache_pkg::reg_word_t pwdata,
	output wire dcache_pkg::reg_word_t prdata
);
	import dcache_pkg::*;

	mem_bus_if mem_bus ();
	dcache_cfg_if cfg ();

	way_oh_t ram_en;
	logic ram_we;
	ram_addr_t ram_addr;
	line_half_t ram_bwen;
	line_half_t ram_wdata;
	line_half_t ram_rdata [NUM_WAYS];

	dcache_ctrl ctrl_inst (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_strb(req_strb),
		.resp_ready(resp_ready),
		.resp_rdata(resp_rdata),
		.mem(mem_bus),
		.cfg(cfg),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_bwen(ram_bwen),
		.ram_wdata(ram_wdata),
		.ram_rdata0(ram_rdata[0]),
		.ram_rdata1(ram_rdata[1]),
		.ram_rdata2(ram_rdata[2]),
		.ram_rdata3(ram_rdata[3])
	);

	// one RAM per way, all sharing address and write data
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		dcache_data_ram ram_inst (
			.clk(clk),
			.en(ram_en[w]),
			.we(ram_we),
			.addr(ram_addr),
			.bwen(ram_bwen),
			.wdata(ram_wdata),
			.rdata(ram_rdata[w])
		);
	end

	dcache_regs regs_inst (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.cfg(cfg)
	);

	backing_mem #(
		.MEM_WORDS(MEM_WORDS)
	) mem_inst (
		.clk(clk),
		.rst(rst),
		.bus(mem_bus)
	);

endmodule

`default_nettype wire

//--- tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// shadow copy of main memory, updated by every store
data_t shadow [MEM_WORDS];
// per-set tags expected in the cache, only trusted while no eviction can happen
logic cached_lines [NUM_SETS][32];
logic model_enable;
logic [31:0] lfsr_state = 32'h6f29_7d7b;

// word i holds 0xC0DE0000 + i above and ~i below
function automatic void init_shadow();
	for (int i = 0; i < MEM_WORDS; i++) begin
		shadow[i] = {32'hC0DE_0000 + 32'(i), ~32'(i)};
	end
endfunction

// word index above bit 2, wrapping at the memory size
function automatic int word_of(input addr_t addr);
	return int'(addr[31:3]) % MEM_WORDS;
endfunction

function automatic data_t expect_read(input addr_t addr);
	return shadow[word_of(addr)];
endfunction

function automatic void shadow_store(input addr_t addr, input data_t data, input strb_t strb);
	int idx;
	idx = word_of(addr);
	for (int b = 0; b < 8; b++) begin
		if (strb[b]) begin
			shadow[idx][b*8 +: 8] = data[b*8 +: 8];
		end
	end
endfunction

// a read hits only when enabled and the tag was filled before
function automatic logic expect_hit(input addr_t addr);
	return model_enable && cached_lines[addr[9:6]][addr[14:10]];
endfunction

// a read with the cache disabled leaves nothing behind
function automatic void note_read(input addr_t addr);
	if (model_enable) begin
		cached_lines[addr[9:6]][addr[14:10]] = 1'b1;
	end
endfunction

function automatic void forget_all();
	for (int s = 0; s < NUM_SETS; s++) begin
		for (int t = 0; t < 32; t++) begin
			cached_lines[s][t] = 1'b0;
		end
	end
endfunction

function automatic addr_t line_addr(input logic [4:0] tag, input set_idx_t set_idx,
	input logic [2:0] beat);
	return {17'b0, tag, set_idx, beat, 3'b0};
endfunction

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function automatic logic [31:0] rand_bits(input int count);
	logic [31:0] result;
	result = '0;
	for (int i = 0; i < count; i++) begin
		lfsr_state = lfsr_step(lfsr_state);
		result = {result[30:0], lfsr_state[0]};
	end
	return result;
endfunction

`endif

//--- tests/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
	import dcache_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	// 32 KiB of memory keeps every test address below 0x8000 unique
	localparam int MEM_WORDS = 4096;
	localparam int EVICT_OPS = 80;
	// cpu and apb operations each bounded by a worst-case miss
	localparam int MAX_OPS = 150;
	localparam int OP_CYCLES = 16;
	localparam int WATCHDOG_NS = (RESET_CYCLES + MAX_OPS * OP_CYCLES) * CLK_PERIOD;

	logic clk = 1'b0;
	logic rst;
	logic req_valid;
	logic req_write;
	addr_t req_addr;
	data_t req_wdata;
	strb_t req_strb;
	logic resp_ready;
	data_t resp_rdata;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	reg_word_t pwdata;
	reg_word_t prdata;

	reg_word_t exp_hits;
	reg_word_t exp_misses;
	// outstanding cpu requests in issue order
	logic pend_is_read [$];
	addr_t pend_addr [$];
	data_t pend_data [$];

	`include "tb_model.svh"

	dcache_top #(
		.MEM_WORDS(MEM_WORDS)
	) dcache_top_inst (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_strb(req_strb),
		.resp_ready(resp_ready),
		.resp_rdata(resp_rdata),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_data(input string what, input data_t got, input data_t expected);
		if (got !== expected) begin
			$display("error at %0d ns: %s: got %h, expected %h", $time, what, got, expected);
			$display("RESULT: FAIL");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_reg(input string what, input reg_word_t got, input reg_word_t expected);
		if (got !== expected) begin
			$display("error at %0d ns: %s: got %h, expected %h", $time, what, got, expected);
			$display("RESULT: FAIL");
			$fatal(1, "register mismatch");
		end
	endtask

	task automatic apb_write(input apb_addr_t addr, input reg_word_t data);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output reg_word_t data);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		data = prdata;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_counters();
		reg_word_t value;
		apb_read(REG_HITS, value);
		check_reg("hit counter", value, exp_hits);
		apb_read(REG_MISSES, value);
		check_reg("miss counter", value, exp_misses);
	endtask

	// keeps enable set and gives the pulse time to reach the controller
	task automatic invalidate_all();
		apb_write(REG_CTRL, 32'h3);
		forget_all();
		repeat (2) @(negedge clk);
	endtask

	task automatic wait_response();
		do begin
			@(negedge clk);
		end while (!resp_ready);
		req_valid = 1'b0;
		req_write = 1'b0;
	endtask

	task automatic cpu_read(input addr_t addr);
		if (expect_hit(addr)) begin
			exp_hits = exp_hits + 32'd1;
		end else begin
			exp_misses = exp_misses + 32'd1;
		end
		note_read(addr);
		@(negedge clk);
		req_valid = 1'b1;
		req_write = 1'b0;
		req_addr = addr;
		req_strb = '0;
		pend_is_read.push_back(1'b1);
		pend_addr.push_back(addr);
		pend_data.push_back(expect_read(addr));
		wait_response();
	endtask

	task automatic cpu_write(input addr_t addr, input data_t data, input strb_t strb);
		shadow_store(addr, data, strb);
		@(negedge clk);
		req_valid = 1'b1;
		req_write = 1'b1;
		req_addr = addr;
		req_wdata = data;
		req_strb = strb;
		pend_is_read.push_back(1'b0);
		pend_addr.push_back(addr);
		pend_data.push_back('0);
		wait_response();
	endtask

	task automatic random_store(input addr_t addr);
		data_t data;
		strb_t strb;
		data = {rand_bits(32), rand_bits(32)};
		strb = strb_t'(rand_bits(8));
		cpu_write(addr, data, strb);
	endtask

	// every response is matched against the oldest outstanding request
	always @(negedge clk) begin : compare_responses
		logic is_read;
		addr_t addr;
		data_t expected;
		if (!rst && resp_ready) begin
			if (pend_is_read.size() == 0) begin
				$display("response at %0d ns arrived with no request outstanding", $time);
				$display("RESULT: FAIL");
				$fatal(1, "unexpected response");
			end else begin
				is_read = pend_is_read.pop_front();
				addr = pend_addr.pop_front();
				expected = pend_data.pop_front();
				if (is_read) begin
					check_data($sformatf("read data at %h", addr), resp_rdata, expected);
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout after %0d ns, the test sequence did not finish", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial begin : stimulus
		addr_t a_line;
		addr_t b_line;
		addr_t b_other;
		addr_t c_line;
		addr_t d_line;
		addr_t addr;
		reg_word_t value;
		rst = 1'b1;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		req_strb = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		init_shadow();
		forget_all();
		model_enable = 1'b1;
		exp_hits = '0;
		exp_misses = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		// miss then hit on one address
		a_line = line_addr(5'd1, 4'd0, 3'd3);
		cpu_read(a_line);
		cpu_read(a_line);
		check_counters();

		// register map
		apb_write(REG_CTRL, 32'h1);
		apb_read(REG_CTRL, value);
		check_reg("ctrl readback", value, 32'h1);
		invalidate_all();
		apb_read(REG_CTRL, value);
		check_reg("ctrl after invalidate", value, 32'h1);
		apb_read(4'hC, value);
		check_reg("unmapped offset", value, 32'h0);

		// store hits and store misses with random masks
		b_line = line_addr(5'd2, 4'd1, 3'd5);
		b_other = line_addr(5'd2, 4'd1, 3'd6);
		c_line = line_addr(5'd3, 4'd2, 3'd0);
		cpu_read(b_line);
		random_store(b_line);
		random_store(b_other);
		random_store(c_line);
		cpu_read(b_line);
		cpu_read(b_other);
		cpu_read(c_line);
		random_store(c_line);
		cpu_read(c_line);
		check_counters();

		// disabled reads neither hit a cached line nor fill a new one
		d_line = line_addr(5'd4, 4'd3, 3'd2);
		apb_write(REG_CTRL, 32'h0);
		model_enable = 1'b0;
		repeat (3) cpu_read(d_line);
		cpu_read(c_line);
		apb_read(REG_CTRL, value);
		check_reg("ctrl disabled", value, 32'h0);
		check_counters();
		apb_write(REG_CTRL, 32'h1);
		model_enable = 1'b1;
		cpu_read(d_line);
		cpu_read(d_line);
		check_counters();

		// invalidate drops every line and a counter write clears both
		invalidate_all();
		cpu_read(b_line);
		cpu_read(c_line);
		cpu_read(d_line);
		check_counters();
		apb_write(REG_MISSES, 32'h1234);
		exp_hits = '0;
		exp_misses = '0;
		check_counters();

		// eight tags fighting over set 5
		for (int i = 0; i < EVICT_OPS; i++) begin
			addr = line_addr(5'(rand_bits(3)), 4'd5, 3'(rand_bits(3)));
			if (rand_bits(2) == 32'd0) begin
				random_store(addr);
			end else begin
				cpu_read(addr);
			end
		end

		repeat (2) @(negedge clk);
		if (pend_is_read.size() == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("%0d requests never got a response", pend_is_read.size());
			$display("RESULT: FAIL");
			$fatal(1, "missing responses");
		end
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+tests
common/dcache_pkg.sv
common/mem_bus_if.sv
common/dcache_cfg_if.sv
dcache/dcache_data_ram.sv
dcache/dcache_regs.sv
dcache/dcache_ctrl.sv
verilog/backing_mem.sv
verilog/dcache_top.sv
tests/tb_dcache.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the data cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module tb_dcache -f tb.f -o tb_dcache_sim

# a $fatal in the testbench gives a nonzero exit status here
./obj_dir/tb_dcache_sim
